//--- wbw.f
design/wbw_pkg.sv
design/addr_aligner.sv
design/transfer_widener.sv
design/wb_narrow_slave.sv
design/wide_sram.sv
design/wbw_top.sv
test/wbw_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = wbw_tb
FILELIST   = wbw.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the binary is lost in the pipe, the log decides
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/wbw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wbw_tb
  import wbw_pkg::*;
();

  // Narrow words held by the whole memory
  localparam int NUM_WORD = MEM_DEPTH * NUM_LANE;
  localparam int BW_WORD_IDX = BW_MEM_IDX + BW_LANE;
  // Random traffic stays in the first 8 rows
  localparam int RAND_WORDS = 32;
  localparam int NUM_RANDOM = 200;
  // Cycles to wait for ack or err
  localparam int TIMEOUT = 16;

  typedef logic [BW_WORD_IDX-1:0] word_idx_t;

  logic  clk;
  logic  rst_n;
  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  data_t dat_w;
  sel_t  sel;
  data_t dat_r;
  logic  ack;
  logic  err;

  // Expected response of the cycle in flight
  logic  exp_err;
  logic  exp_read;
  data_t exp_rdata;

  // Reference memory, one entry per narrow word
  data_t model_mem [NUM_WORD];
  logic  written [NUM_WORD];

  int seed;

  wbw_top UUT (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
    .adr(adr), .dat_w(dat_w), .sel(sel), .dat_r(dat_r),
    .ack(ack), .err(err)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // **************************************************
  // Helpers
  // **************************************************

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Misaligned or past the last byte of the memory
  function automatic logic addr_is_bad(input addr_t addr);
    return (addr[1:0] != 2'b00) || (addr >= addr_t'(MEM_DEPTH * NUM_WIDE_BYTE));
  endfunction

  // Old word with only the enabled bytes replaced
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input sel_t bsel);
    data_t result;
    result = old_word;
    for (int b = 0; b < NUM_BYTE; b++)
    begin
      if (bsel[b])
        result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  // One Wishbone classic cycle, driven on falling edges
  task automatic bus_cycle(input logic write, input addr_t addr, input data_t data,
                           input sel_t bsel);
    logic      bad;
    word_idx_t idx;
    int        cycles;
    bad = addr_is_bad(addr);
    idx = addr[BW_WORD_IDX+1:2];
    // Leaves stb low for at least one rising edge
    @(negedge clk);
    exp_err = bad;
    exp_read = !write && !bad;
    if (exp_read)
      exp_rdata = model_mem[idx];
    // Model follows good writes only
    if (write && !bad)
    begin
      model_mem[idx] = merge_bytes(model_mem[idx], data, bsel);
      written[idx] = 1'b1;
    end
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    dat_w = data;
    sel = bsel;
    cycles = 0;
    while (!(ack || err))
    begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("no ack or err within %0d cycles, adr 0x%08h", TIMEOUT, addr);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
    end
    // Response seen mid cycle, release the bus
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wb_write(input addr_t addr, input data_t data, input sel_t bsel);
    bus_cycle(1'b1, addr, data, bsel);
  endtask

  task automatic wb_read(input addr_t addr);
    bus_cycle(1'b0, addr, '0, 4'hf);
  endtask

  // **************************************************
  // Checks
  // **************************************************

  // Quiet response lines in reset and on the first edge after it
  assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> !(ack || err))
    else fail_run($sformatf("error ack/err in reset expected 0/0 got %h/%h",
                            $sampled(ack), $sampled(err)));

  // Answer kind one cycle after the request is sampled
  assert property (@(posedge clk) disable iff (!rst_n)
                   (cyc && stb) |=> (ack == !exp_err) && (err == exp_err))
    else fail_run($sformatf("error ack/err expected %h/%h got %h/%h",
                            !exp_err, exp_err, $sampled(ack), $sampled(err)));

  // Response lasts a single cycle
  assert property (@(posedge clk) disable iff (!rst_n) (ack || err) |=> !(ack || err))
    else fail_run($sformatf("error ack/err expected 0/0 got %h/%h",
                            $sampled(ack), $sampled(err)));

  assert property (@(posedge clk) disable iff (!rst_n) (ack || err) |-> $past(cyc && stb))
    else fail_run("ack or err came without a request");

  // Read data against the reference model
  assert property (@(posedge clk) disable iff (!rst_n) (ack && exp_read) |-> (dat_r == exp_rdata))
    else fail_run($sformatf("error dat_r expected 0x%08h got 0x%08h",
                            exp_rdata, $sampled(dat_r)));

  // **************************************************
  // Stimulus
  // **************************************************

  initial
  begin : stimulus
    word_idx_t rnd_idx;
    addr_t     rnd_addr;
    clk = 1'b0;
    rst_n = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    sel = '0;
    exp_err = 1'b0;
    exp_read = 1'b0;
    exp_rdata = '0;
    seed = 54452;
    for (int i = 0; i < NUM_WORD; i++)
    begin
      model_mem[i] = '0;
      written[i] = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Full word round trip
    wb_write(32'h0000_0020, 32'hCAFE_F00D, 4'hf);
    wb_read(32'h0000_0020);

    // Four lanes of row 4, then each read back
    for (int i = 0; i < NUM_LANE; i++)
      wb_write(addr_t'(32'h40 + 4 * i), data_t'(32'h1100_0000 * (i + 1) + i), 4'hf);
    for (int i = 0; i < NUM_LANE; i++)
      wb_read(addr_t'(32'h40 + 4 * i));

    // Partial byte enables merged into a known word
    wb_write(32'h0000_0084, 32'h0123_4567, 4'hf);
    wb_write(32'h0000_0084, 32'hAABB_CCDD, 4'b0101);
    wb_read(32'h0000_0084);
    wb_write(32'h0000_0084, 32'hEEFF_0011, 4'b1000);
    wb_read(32'h0000_0084);
    wb_write(32'h0000_0084, 32'h9988_7766, 4'b0010);
    wb_read(32'h0000_0084);

    // Misaligned access leaves the neighbor alone
    wb_write(32'h0000_0010, 32'hA5A5_0001, 4'hf);
    wb_write(32'h0000_0012, 32'hDEAD_BEEF, 4'hf);
    wb_read(32'h0000_0011);
    wb_read(32'h0000_0010);

    // Out of range aliases onto row 0 if not blocked
    wb_write(32'h0000_0000, 32'h1111_2222, 4'hf);
    wb_write(32'h0000_0400, 32'h3333_4444, 4'hf);
    wb_write(32'h8000_0000, 32'h5555_6666, 4'hf);
    wb_read(32'h0000_0400);
    wb_read(32'h0000_0000);

    // Last word is still inside
    wb_write(32'h0000_03FC, 32'h7777_8888, 4'hf);
    wb_read(32'h0000_03FC);

    // Random traffic, reads only of written words
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      rnd_idx = word_idx_t'($random(seed) & (RAND_WORDS - 1));
      rnd_addr = addr_t'({rnd_idx, 2'b00});
      if (written[rnd_idx] && (($random(seed) & 1) != 0))
        wb_read(rnd_addr);
      else if (written[rnd_idx])
        wb_write(rnd_addr, data_t'($random(seed)), sel_t'($random(seed)));
      else
        wb_write(rnd_addr, data_t'($random(seed)), 4'hf);
    end

    // Let the last response pass its checks
    repeat (3) @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/wbw_top.sv
`timescale 1ns/1ps
`default_nettype none

module wbw_top
(
  input  wire                   clk,
  input  wire                   rst_n,

  // Wishbone classic slave port
  input  wire                   cyc,
  input  wire                   stb,
  input  wire                   we,
  input  wire wbw_pkg::addr_t   adr,
  input  wire wbw_pkg::data_t   dat_w,
  input  wire wbw_pkg::sel_t    sel,
  output wire wbw_pkg::data_t   dat_r,
  output wire                   ack,
  output wire                   err
);

  // **************************************************
  // Internal nets
  // **************************************************

  // Memory control
  wire mem_en;
  wire mem_we;

  // Address split
  wire addr_bad;
  wire wbw_pkg::mem_idx_t mem_idx;
  wire wbw_pkg::lane_t lane;
  wire wbw_pkg::lane_onehot_t lane_onehot;
  wire wbw_pkg::lane_t rd_lane;

  // Wide data path
  wire wbw_pkg::wide_data_t wide_wdata;
  wire wbw_pkg::wide_sel_t wide_wbyteen;
  wire wbw_pkg::wide_data_t wide_rdata;

  // Request strobe already folded into mem_en inside the slave
  wb_narrow_slave u_slave (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
    .addr_bad(addr_bad), .lane(lane), .ack(ack), .err(err),
    .req_valid(), .mem_en(mem_en), .mem_we(mem_we), .rd_lane(rd_lane)
  );

  addr_aligner u_aligner (
    .adr(adr), .mem_idx(mem_idx), .lane(lane),
    .lane_onehot(lane_onehot), .addr_bad(addr_bad)
  );

  transfer_widener u_widener (
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .lane_onehot(lane_onehot),
    .rd_lane(rd_lane), .wide_wdata(wide_wdata),
    .wide_wbyteen(wide_wbyteen), .wide_rdata(wide_rdata)
  );

  wide_sram u_sram (
    .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_idx(mem_idx),
    .wide_wdata(wide_wdata), .wide_wbyteen(wide_wbyteen),
    .wide_rdata(wide_rdata)
  );

endmodule

`default_nettype wire

//--- design/wide_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wide_sram
  import wbw_pkg::*;
(
  input  wire             clk,

  // Access control from the slave
  input  wire             mem_en,
  input  wire             mem_we,

  // Row address from the aligner
  input  wire mem_idx_t   mem_idx,

  // Write path from the widener
  input  wire wide_data_t wide_wdata,
  input  wire wide_sel_t  wide_wbyteen,

  // Registered read word
  output wide_data_t      wide_rdata
);

  // **************************************************
  // Storage
  // **************************************************

  // Contents start undefined
  wide_data_t mem [MEM_DEPTH];

  // **************************************************
  // Access port
  // **************************************************

  // Single port, write or read per enabled edge
  always_ff @(posedge clk)
  begin
    if (mem_en)
    begin
      if (mem_we)
      begin
        // Only enabled bytes change
        for (int b = 0; b < NUM_WIDE_BYTE; b++)
        begin
          if (wide_wbyteen[b])
            mem[mem_idx][8*b +: 8] <= wide_wdata[8*b +: 8];
        end
      end
      else
      begin
        // Read data shows up after this edge
        wide_rdata <= mem[mem_idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/wb_narrow_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_narrow_slave
  import wbw_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  // Wishbone classic control
  input  wire        cyc,
  input  wire        stb,
  input  wire        we,
  output logic       ack,
  output logic       err,

  // From the aligner
  input  wire        addr_bad,
  input  wire lane_t lane,

  // Request strobe and memory control
  output logic       req_valid,
  output logic       mem_en,
  output logic       mem_we,

  // Lane of the request in flight
  output lane_t      rd_lane
);

  slave_state_t state;
  slave_state_t state_nxt;

  // Response kind chosen when the request is taken
  logic resp_err;

  // **************************************************
  // Request acceptance
  // **************************************************

  // One cycle strobe, only while idle
  assign req_valid = (state == S_IDLE) && cyc && stb;

  // Bad addresses never reach the memory
  assign mem_en = req_valid && !addr_bad;
  assign mem_we = mem_en && we;

  // **************************************************
  // State machine
  // **************************************************

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_IDLE:
      begin
        if (req_valid)
          state_nxt = S_RESP;
      end
      // Answer lasts one cycle
      S_RESP:
        state_nxt = S_IDLE;
      default:
        state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      resp_err <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (req_valid)
        resp_err <= addr_bad;
    end
  end

  // Lane kept for the read mux while answering
  always_ff @(posedge clk)
  begin
    if (req_valid)
      rd_lane <= lane;
  end

  // Exactly one of ack or err while answering
  assign ack = (state == S_RESP) && !resp_err;
  assign err = (state == S_RESP) && resp_err;

  // **************************************************
  // Protocol checks
  // **************************************************

  assert property (@(posedge clk) disable iff (!rst_n) !(ack && err))
    else $error("ack and err high together");

  assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else $error("ack high in two consecutive cycles");

endmodule

`default_nettype wire

//--- design/transfer_widener.sv
`timescale 1ns/1ps
`default_nettype none

module transfer_widener
  import wbw_pkg::*;
(
  // Narrow side
  input  wire data_t        dat_w,
  input  wire sel_t         sel,
  output data_t             dat_r,

  // Lane info from the aligner and the slave
  input  wire lane_onehot_t lane_onehot,
  input  wire lane_t        rd_lane,

  // Wide memory side
  output wide_data_t        wide_wdata,
  output wide_sel_t         wide_wbyteen,
  input  wire wide_data_t   wide_rdata
);

  // Read slices of the wide word, one per lane
  data_t rd_slice [NUM_LANE];

  // Lanes that carry at least one enabled byte
  logic [NUM_LANE-1:0] lane_active;

  // **************************************************
  // Write widening and read slicing per lane
  // **************************************************

  for (genvar i = 0; i < NUM_LANE; i++)
  begin : g_lane
    // Same narrow data on every lane
    assign wide_wdata[BW_DATA*i +: BW_DATA] = dat_w;

    // Byte enables only on the selected lane
    assign wide_wbyteen[NUM_BYTE*i +: NUM_BYTE] = lane_onehot[i] ? sel : '0;

    // Slice of the wide read word for this lane
    assign rd_slice[i] = wide_rdata[BW_DATA*i +: BW_DATA];

    assign lane_active[i] = |wide_wbyteen[NUM_BYTE*i +: NUM_BYTE];
  end

  // **************************************************
  // Read narrowing
  // **************************************************

  // Lane registered by the slave at request time,
  // the live address may already have moved on
  assign dat_r = rd_slice[rd_lane];

  // A narrow write never touches two lanes
  always_comb
  begin
    if (!$isunknown(lane_active))
    begin
      assert ($onehot0(lane_active))
        else $error("wide_wbyteen spans lanes: %h", wide_wbyteen);
    end
  end

endmodule

`default_nettype wire

//--- design/addr_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module addr_aligner
  import wbw_pkg::*;
(
  input  wire addr_t        adr,
  output mem_idx_t          mem_idx,
  output lane_t             lane,
  output lane_onehot_t      lane_onehot,
  output logic              addr_bad
);

  // Low address bits that select a byte inside a narrow word
  localparam int BW_NARROW_OFFSET = BW_WIDE_OFFSET - BW_LANE;
  // First address bit above the last memory row
  localparam int TOP_BIT = BW_WIDE_OFFSET + BW_MEM_IDX;

  logic misaligned;
  logic out_of_range;

  // **************************************************
  // Address split
  // **************************************************

  // Row index sits right above the wide byte offset
  assign mem_idx = adr[BW_WIDE_OFFSET +: BW_MEM_IDX];

  // Lane sits between the narrow and the wide offset
  assign lane = adr[BW_NARROW_OFFSET +: BW_LANE];

  // Lane decode to one-hot
  assign lane_onehot = lane_onehot_t'(1) << lane;

  // **************************************************
  // Address checks
  // **************************************************

  // Only word aligned accesses are served
  assign misaligned = |adr[BW_NARROW_OFFSET-1:0];

  // Any bit above the memory size means beyond the last row
  assign out_of_range = |adr[BW_ADDR-1:TOP_BIT];

  assign addr_bad = misaligned || out_of_range;

  // Decoded mask must select exactly one lane
  always_comb
  begin
    if (!$isunknown(lane))
    begin
      assert ($onehot(lane_onehot))
        else $error("lane_onehot not one-hot: %h", lane_onehot);
    end
  end

endmodule

`default_nettype wire

//--- design/wbw_pkg.sv
`default_nettype none

package wbw_pkg;

  // **************************************************
  // Bus and memory geometry
  // **************************************************

  // Wishbone byte address
  localparam int BW_ADDR = 32;
  // Narrow data bus seen by the master
  localparam int BW_DATA = 32;
  // One row of the on-chip memory
  localparam int BW_WIDE_DATA = 128;

  // Byte counts per word
  localparam int NUM_BYTE = BW_DATA / 8;
  localparam int NUM_WIDE_BYTE = BW_WIDE_DATA / 8;

  // Narrow lanes packed into one wide row
  localparam int NUM_LANE = BW_WIDE_DATA / BW_DATA;
  localparam int BW_LANE = 2;

  // Byte offset bits inside a wide row
  localparam int BW_WIDE_OFFSET = 4;

  // Rows in the memory and the index width
  localparam int MEM_DEPTH = 64;
  localparam int BW_MEM_IDX = 6;

  // **************************************************
  // Vector types
  // **************************************************

  typedef logic [BW_ADDR-1:0] addr_t;
  typedef logic [BW_DATA-1:0] data_t;
  typedef logic [NUM_BYTE-1:0] sel_t;
  typedef logic [BW_WIDE_DATA-1:0] wide_data_t;
  typedef logic [NUM_WIDE_BYTE-1:0] wide_sel_t;
  typedef logic [BW_LANE-1:0] lane_t;
  typedef logic [NUM_LANE-1:0] lane_onehot_t;
  typedef logic [BW_MEM_IDX-1:0] mem_idx_t;

  // Slave FSM, idle or answering
  typedef enum logic [0:0] {S_IDLE, S_RESP} slave_state_t;

endpackage

`default_nettype wire
